/* hw/alpha_pkg.sv */
package alpha_pkg;

	// ------------------------------------------------------------------------
	// readout word format
	// ------------------------------------------------------------------------
	localparam int alpha_word_w = 16;
	localparam int sample_count_w = 4;

	// first word of every packet carries this marker
	localparam logic [3:0] header_marker = 4'ha;

	// header view, count of sample words that follow
	typedef struct packed {
		logic [3:0] marker;
		logic [7:0] window;
		logic [sample_count_w-1:0] sample_count;
	} alpha_header_t;

	// sample view
	typedef struct packed {
		logic [3:0] channel;
		logic [11:0] adc;
	} alpha_sample_t;

	typedef union packed {
		alpha_header_t hdr;
		alpha_sample_t sample;
	} alpha_word_u;

	// ------------------------------------------------------------------------
	// bias DAC serial frames
	// ------------------------------------------------------------------------
	localparam int bias_value_w = 12;
	localparam int bias_addr_w = 4;

	// address then value, msb first
	localparam int bias_frame_w = bias_addr_w + bias_value_w;

endpackage

/* hw/board_pkg.sv */
package board_pkg;

	// ------------------------------------------------------------------------
	// startup phases, in the order they run
	// ------------------------------------------------------------------------
	typedef enum logic [2:0] {
		phase_settle,
		phase_dreset,
		phase_pre_bias,
		phase_bias_load,
		phase_wait_press,
		phase_running
	} startup_phase_e;

	// one status bit per phase
	localparam int startup_phase_n = 6;

	// ------------------------------------------------------------------------
	// bias register addresses on the ASIC serial bus
	// ------------------------------------------------------------------------
	localparam logic [alpha_pkg::bias_addr_w-1:0] bias_addr_cmp = 4'd0;
	localparam logic [alpha_pkg::bias_addr_w-1:0] bias_addr_isel = 4'd1;
	localparam logic [alpha_pkg::bias_addr_w-1:0] bias_addr_sb = 4'd2;
	localparam logic [alpha_pkg::bias_addr_w-1:0] bias_addr_db = 4'd3;

endpackage

/* hw/button_debounce.sv */
`timescale 1ns/10ps

module button_debounce #(
	parameter int debounce_cycles = 1000
) (
	input logic sysclk,
	input logic reset,
	input logic button,
	output logic press
);
	localparam int count_w = $clog2(debounce_cycles + 1);

	logic button_meta;
	logic button_sync;
	// debounced level
	logic level;
	logic [count_w-1:0] stable_count;

	always_ff @(posedge sysclk) begin
		if (reset) begin
			button_meta <= 1'b0;
			button_sync <= 1'b0;
			level <= 1'b0;
			stable_count <= '0;
			press <= 1'b0;
		end else begin
			button_meta <= button;
			button_sync <= button_meta;
			press <= 1'b0;
			// any return to the old level restarts the count
			if (button_sync == level) begin
				stable_count <= '0;
			end else if (stable_count == count_w'(debounce_cycles - 1)) begin
				level <= button_sync;
				stable_count <= '0;
				// pulse on the rising edge only
				press <= button_sync;
			end else begin
				stable_count <= stable_count + 1'b1;
			end
		end
	end

endmodule

/* hw/startup_sequencer.sv */
`timescale 1ns/10ps

module startup_sequencer import board_pkg::*; #(
	parameter int settle_cycles = 64,
	parameter int dreset_cycles = 8
) (
	input logic sysclk,
	input logic reset,
	input logic press,
	input logic load_ready,
	input logic load_done,
	output logic load_valid,
	output logic dreset,
	output logic sync,
	output logic readout_enable,
	output logic [startup_phase_n-1:0] phase_led
);
	localparam int count_max = (settle_cycles > dreset_cycles) ? settle_cycles : dreset_cycles;
	localparam int count_w = $clog2(count_max + 1);

	startup_phase_e phase;
	logic [count_w-1:0] count;
	logic [count_w-1:0] wait_limit;
	logic wait_over;
	// request already taken by the shifter
	logic load_taken;

	assign wait_limit = (phase == phase_dreset) ? count_w'(dreset_cycles - 1)
		: count_w'(settle_cycles - 1);
	assign wait_over = (count == wait_limit);

	assign dreset = (phase == phase_dreset);
	assign load_valid = (phase == phase_bias_load) && !load_taken;
	assign readout_enable = (phase == phase_running);

	always_ff @(posedge sysclk) begin
		if (reset) begin
			phase <= phase_settle;
			count <= '0;
			load_taken <= 1'b0;
			sync <= 1'b0;
			phase_led <= '0;
		end else begin
			sync <= 1'b0;
			case (phase)
				// timed phases share the one counter
				phase_settle, phase_dreset, phase_pre_bias: begin
					if (wait_over) begin
						count <= '0;
						phase_led[phase] <= 1'b1;
						phase <= startup_phase_e'(phase + 3'd1);
					end else begin
						count <= count + 1'b1;
					end
				end
				phase_bias_load: begin
					if (load_valid && load_ready) begin
						load_taken <= 1'b1;
					end
					if (load_done) begin
						phase_led[phase_bias_load] <= 1'b1;
						phase <= phase_wait_press;
					end
				end
				phase_wait_press: begin
					if (press) begin
						sync <= 1'b1;
						phase_led[phase_wait_press] <= 1'b1;
						phase_led[phase_running] <= 1'b1;
						phase <= phase_running;
					end
				end
				phase_running: begin
					// stays here until reset
				end
				default: phase <= phase_settle;
			endcase
		end
	end

endmodule

/* hw/bias_shifter.sv */
`timescale 1ns/10ps

module bias_shifter import alpha_pkg::*, board_pkg::*; (
	input logic sysclk,
	input logic reset,
	input logic load_valid,
	output logic load_ready,
	output logic load_done,
	input logic [bias_value_w-1:0] cmp_bias,
	input logic [bias_value_w-1:0] isel_bias,
	input logic [bias_value_w-1:0] sb_bias,
	input logic [bias_value_w-1:0] db_bias,
	output logic sin,
	output logic sclk,
	output logic pclk
);
	localparam int frame_n = 4;
	localparam int frame_idx_w = $clog2(frame_n);
	// two cycles per bit, then the pclk step
	localparam int step_last = 2 * bias_frame_w;
	localparam int step_w = $clog2(step_last + 1);
	localparam int bit_w = $clog2(bias_frame_w);

	logic busy;
	logic [frame_idx_w-1:0] frame_idx;
	logic [step_w-1:0] step;
	logic [bit_w-1:0] bit_idx;
	logic shifting;
	logic [bias_value_w-1:0] bias_q [frame_n];
	logic [bias_frame_w-1:0] frame;

	assign load_ready = !busy;

	// fixed order cmp, isel, sb, db
	always_comb begin
		case (frame_idx)
			2'd0: frame = {bias_addr_cmp, bias_q[0]};
			2'd1: frame = {bias_addr_isel, bias_q[1]};
			2'd2: frame = {bias_addr_sb, bias_q[2]};
			default: frame = {bias_addr_db, bias_q[3]};
		endcase
	end

	// ------------------------------------------------------------------------
	// serial lines, sin set up while sclk is low
	// ------------------------------------------------------------------------
	assign shifting = busy && (step < step_w'(step_last));
	assign bit_idx = step[bit_w:1];
	assign sin = shifting && frame[bias_frame_w - 1 - bit_idx];
	assign sclk = shifting && step[0];
	assign pclk = busy && (step == step_w'(step_last));

	always_ff @(posedge sysclk) begin
		if (load_valid && load_ready) begin
			bias_q[0] <= cmp_bias;
			bias_q[1] <= isel_bias;
			bias_q[2] <= sb_bias;
			bias_q[3] <= db_bias;
		end
	end

	always_ff @(posedge sysclk) begin
		if (reset) begin
			busy <= 1'b0;
			frame_idx <= '0;
			step <= '0;
			load_done <= 1'b0;
		end else begin
			load_done <= 1'b0;
			if (!busy) begin
				if (load_valid && load_ready) begin
					busy <= 1'b1;
					frame_idx <= '0;
					step <= '0;
				end
			end else if (step == step_w'(step_last)) begin
				step <= '0;
				frame_idx <= frame_idx + 1'b1;
				if (frame_idx == frame_idx_w'(frame_n - 1)) begin
					busy <= 1'b0;
					load_done <= 1'b1;
				end
			end else begin
				step <= step + 1'b1;
			end
		end
	end

endmodule

/* hw/alpha_readout.sv */
`timescale 1ns/10ps

module alpha_readout import alpha_pkg::*; (
	input logic sysclk,
	input logic reset,
	input logic readout_enable,
	input logic data_a,
	output logic word_valid,
	output logic [alpha_word_w-1:0] word,
	output logic header,
	output logic msn
);
	localparam int bit_w = $clog2(alpha_word_w);
	// index of the last bit of the top nybble
	localparam int msn_bit = 3;

	logic in_frame;
	logic [bit_w-1:0] bit_count;
	logic [alpha_word_w-2:0] shreg;
	logic frame_end;
	alpha_word_u next_word;
	// sample words still due in this packet
	logic [sample_count_w-1:0] samples_left;
	logic expect_header;

	assign next_word = {shreg, data_a};
	assign frame_end = in_frame && (bit_count == bit_w'(alpha_word_w - 1));
	assign expect_header = (samples_left == '0);

	// ------------------------------------------------------------------------
	// start-bit framer and packet tracker
	// ------------------------------------------------------------------------
	always_ff @(posedge sysclk) begin
		if (reset || !readout_enable) begin
			in_frame <= 1'b0;
			bit_count <= '0;
			samples_left <= '0;
			word_valid <= 1'b0;
			header <= 1'b0;
			msn <= 1'b0;
		end else begin
			word_valid <= 1'b0;
			header <= 1'b0;
			msn <= 1'b0;
			if (!in_frame) begin
				if (data_a) begin
					in_frame <= 1'b1;
					bit_count <= '0;
				end
			end else begin
				bit_count <= bit_count + 1'b1;
				if (bit_count == bit_w'(msn_bit)) begin
					msn <= 1'b1;
				end
				if (frame_end) begin
					in_frame <= 1'b0;
					word_valid <= 1'b1;
					header <= expect_header;
					if (expect_header) begin
						// bad marker starts no samples
						if (next_word.hdr.marker == header_marker) begin
							samples_left <= next_word.hdr.sample_count;
						end
					end else begin
						samples_left <= samples_left - 1'b1;
					end
				end
			end
		end
	end

	// data path
	always_ff @(posedge sysclk) begin
		if (in_frame) begin
			shreg <= next_word[alpha_word_w-2:0];
		end
		if (frame_end) begin
			word <= next_word;
		end
	end

endmodule

/* hw/alpha_test_top.sv */
`timescale 1ns/10ps

module alpha_test_top import alpha_pkg::*, board_pkg::*; #(
	parameter int settle_cycles = 64,
	parameter int dreset_cycles = 8,
	parameter int debounce_cycles = 1000
) (
	input logic sysclk,
	input logic reset,
	input logic data_a,
	input logic button,
	input logic [bias_value_w-1:0] cmp_bias,
	input logic [bias_value_w-1:0] isel_bias,
	input logic [bias_value_w-1:0] sb_bias,
	input logic [bias_value_w-1:0] db_bias,
	output logic dreset,
	output logic sin,
	output logic sclk,
	output logic pclk,
	output logic sync,
	output logic word_valid,
	output logic [alpha_word_w-1:0] word,
	output logic header,
	output logic msn,
	output logic [startup_phase_n-1:0] phase_led
);
	logic press;
	logic load_valid;
	logic load_ready;
	logic load_done;
	logic readout_enable;

	button_debounce #(
		.debounce_cycles(debounce_cycles)
	) button_debounce_i (
		.sysclk(sysclk),
		.reset(reset),
		.button(button),
		.press(press)
	);

	startup_sequencer #(
		.settle_cycles(settle_cycles),
		.dreset_cycles(dreset_cycles)
	) startup_sequencer_i (
		.sysclk(sysclk),
		.reset(reset),
		.press(press),
		.load_ready(load_ready),
		.load_done(load_done),
		.load_valid(load_valid),
		.dreset(dreset),
		.sync(sync),
		.readout_enable(readout_enable),
		.phase_led(phase_led)
	);

	// bias DAC load over sin/sclk/pclk
	bias_shifter bias_shifter_i (
		.sysclk(sysclk),
		.reset(reset),
		.load_valid(load_valid),
		.load_ready(load_ready),
		.load_done(load_done),
		.cmp_bias(cmp_bias),
		.isel_bias(isel_bias),
		.sb_bias(sb_bias),
		.db_bias(db_bias),
		.sin(sin),
		.sclk(sclk),
		.pclk(pclk)
	);

	alpha_readout alpha_readout_i (
		.sysclk(sysclk),
		.reset(reset),
		.readout_enable(readout_enable),
		.data_a(data_a),
		.word_valid(word_valid),
		.word(word),
		.header(header),
		.msn(msn)
	);

endmodule

/* bench/tb_alpha_test.sv */
`timescale 1ns/10ps

module tb_alpha_test import alpha_pkg::*, board_pkg::*; ();

	localparam int settle_cycles = 16;
	localparam int dreset_cycles = 8;
	localparam int debounce_cycles = 20;

	logic sysclk;
	logic reset;
	logic data_a;
	logic button;
	logic [bias_value_w-1:0] cmp_bias;
	logic [bias_value_w-1:0] isel_bias;
	logic [bias_value_w-1:0] sb_bias;
	logic [bias_value_w-1:0] db_bias;
	logic dreset;
	logic sin;
	logic sclk;
	logic pclk;
	logic sync;
	logic word_valid;
	logic [alpha_word_w-1:0] word;
	logic header;
	logic msn;
	logic [startup_phase_n-1:0] phase_led;

	// cycles since reset release
	int cycle_count;

	// ASIC line model, bits still to send and the words they carry
	bit line_bits[$];
	logic [alpha_word_w-1:0] sent_words[$];
	bit sent_headers[$];

	alpha_test_top #(
		.settle_cycles(settle_cycles),
		.dreset_cycles(dreset_cycles),
		.debounce_cycles(debounce_cycles)
	) alpha_test_top_i (
		.sysclk(sysclk),
		.reset(reset),
		.data_a(data_a),
		.button(button),
		.cmp_bias(cmp_bias),
		.isel_bias(isel_bias),
		.sb_bias(sb_bias),
		.db_bias(db_bias),
		.dreset(dreset),
		.sin(sin),
		.sclk(sclk),
		.pclk(pclk),
		.sync(sync),
		.word_valid(word_valid),
		.word(word),
		.header(header),
		.msn(msn),
		.phase_led(phase_led)
	);

	always #4 sysclk = ~sysclk;

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	// inputs change and outputs are read 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge sysclk);
		#1;
		if (!reset) begin
			cycle_count++;
		end
	endtask

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("mismatch in %s: expected %0h, actual %0h", name, expected, actual);
			$display("Simulation FAILED");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic wait_timed_out(input string what);
		$display("timeout: %s", what);
		$display("Simulation FAILED");
		$fatal(1, "wait timed out");
	endtask

	function automatic logic [alpha_word_w-1:0] make_header(input int count);
		alpha_word_u w;
		w.hdr.marker = header_marker;
		w.hdr.window = 8'($urandom);
		w.hdr.sample_count = sample_count_w'(count);
		return w;
	endfunction

	function automatic logic [alpha_word_w-1:0] make_sample();
		alpha_word_u w;
		w.sample.channel = 4'($urandom);
		w.sample.adc = 12'($urandom);
		return w;
	endfunction

	// start bit, then the word msb first
	task automatic queue_frame(input logic [alpha_word_w-1:0] value, input bit is_header);
		line_bits.push_back(1'b1);
		for (int i = alpha_word_w - 1; i >= 0; i--) begin
			line_bits.push_back(value[i]);
		end
		sent_words.push_back(value);
		sent_headers.push_back(is_header);
	endtask

	// ------------------------------------------------------------------------
	// tests
	// ------------------------------------------------------------------------
	task automatic test_reset_idle();
		reset = 1'b1;
		repeat (5) begin
			next_cycle();
			check("test_reset_idle", 0, 32'({dreset, sin, sclk, pclk, sync, word_valid,
				header, msn, phase_led}));
		end
		reset = 1'b0;
		next_cycle();
		check("test_reset_idle", 0, 32'({dreset, sin, sclk, pclk, sync, word_valid,
			header, msn, phase_led}));
	endtask

	task automatic test_dreset_pulse();
		int wait_n;
		int high_n;
		wait_n = 0;
		while (!dreset) begin
			if (wait_n == 4 * settle_cycles) begin
				wait_timed_out("dreset never rose after reset");
			end
			next_cycle();
			wait_n++;
		end
		if (cycle_count < settle_cycles - 1 || cycle_count > settle_cycles + 1) begin
			check("test_dreset_pulse delay", settle_cycles, cycle_count);
		end
		high_n = 0;
		while (dreset) begin
			if (high_n == 4 * dreset_cycles) begin
				wait_timed_out("dreset stayed high");
			end
			next_cycle();
			high_n++;
		end
		check("test_dreset_pulse width", dreset_cycles, high_n);
	endtask

	task automatic test_bias_load();
		logic [alpha_word_w-1:0] expected [4];
		logic [alpha_word_w-1:0] shifted;
		int sclk_n;
		int frame_n;
		int wait_n;
		int last_pclk;
		cmp_bias = bias_value_w'($urandom);
		isel_bias = bias_value_w'($urandom);
		sb_bias = bias_value_w'($urandom);
		db_bias = bias_value_w'($urandom);
		expected[0] = {bias_addr_cmp, cmp_bias};
		expected[1] = {bias_addr_isel, isel_bias};
		expected[2] = {bias_addr_sb, sb_bias};
		expected[3] = {bias_addr_db, db_bias};
		shifted = '0;
		sclk_n = 0;
		frame_n = 0;
		wait_n = 0;
		last_pclk = 0;
		while (frame_n < 4) begin
			if (wait_n == 400) begin
				wait_timed_out("bias load did not finish four frames");
			end
			next_cycle();
			wait_n++;
			// sin is stable while sclk is high
			if (sclk) begin
				shifted = {shifted[alpha_word_w-2:0], sin};
				sclk_n++;
			end
			if (pclk) begin
				check("test_bias_load frame", 32'(expected[frame_n]), 32'(shifted));
				check("test_bias_load sclk count", alpha_word_w, sclk_n);
				if (frame_n > 0) begin
					check("test_bias_load frame period", 2 * alpha_word_w + 1,
						cycle_count - last_pclk);
				end
				last_pclk = cycle_count;
				shifted = '0;
				sclk_n = 0;
				frame_n++;
			end
		end
	endtask

	task automatic test_button();
		int wait_n;
		int sync_n;
		// glitch shorter than the debounce window
		button = 1'b1;
		repeat (5) begin
			next_cycle();
		end
		button = 1'b0;
		repeat (40) begin
			next_cycle();
			check("test_button glitch", 0, 32'(sync));
		end
		button = 1'b1;
		wait_n = 0;
		while (!sync) begin
			if (wait_n == 10 * debounce_cycles) begin
				wait_timed_out("no sync after a held press");
			end
			next_cycle();
			wait_n++;
		end
		if (wait_n < debounce_cycles + 2 || wait_n > debounce_cycles + 4) begin
			check("test_button sync delay", debounce_cycles + 3, wait_n);
		end
		sync_n = 1;
		check("test_button phase_led", (1 << startup_phase_n) - 1, 32'(phase_led));
		repeat (30) begin
			next_cycle();
			if (sync) begin
				sync_n++;
			end
		end
		button = 1'b0;
		repeat (40) begin
			next_cycle();
			if (sync) begin
				sync_n++;
			end
		end
		// second press, already running
		button = 1'b1;
		repeat (3 * debounce_cycles) begin
			next_cycle();
			if (sync) begin
				sync_n++;
			end
		end
		button = 1'b0;
		check("test_button sync pulses", 1, sync_n);
	endtask

	task automatic test_readout_packets();
		int frames;
		int valid_n;
		int wait_n;
		bit msn_seen;
		logic [alpha_word_w-1:0] exp_word;
		bit exp_header;
		queue_frame(make_header(3), 1'b1);
		repeat (3) begin
			queue_frame(make_sample(), 1'b0);
		end
		// empty packet, then the next header back to back
		queue_frame(make_header(0), 1'b1);
		queue_frame(make_header(2), 1'b1);
		repeat (2) begin
			queue_frame(make_sample(), 1'b0);
		end
		frames = sent_words.size();
		valid_n = 0;
		wait_n = 0;
		msn_seen = 1'b0;
		while (valid_n < frames) begin
			if (wait_n == (alpha_word_w + 1) * frames + 40) begin
				wait_timed_out("readout did not deliver every frame");
			end
			if (line_bits.size() > 0) begin
				data_a = line_bits.pop_front();
			end else begin
				data_a = 1'b0;
			end
			next_cycle();
			wait_n++;
			if (msn) begin
				check("test_readout_packets msn once", 0, 32'(msn_seen));
				msn_seen = 1'b1;
			end
			if (word_valid) begin
				check("test_readout_packets msn first", 1, 32'(msn_seen));
				msn_seen = 1'b0;
				exp_word = sent_words.pop_front();
				exp_header = sent_headers.pop_front();
				check("test_readout_packets word", 32'(exp_word), 32'(word));
				check("test_readout_packets header", 32'(exp_header), 32'(header));
				valid_n++;
			end
		end
		// line idle, nothing more should come out
		data_a = 1'b0;
		repeat (40) begin
			next_cycle();
			if (word_valid) begin
				valid_n++;
			end
		end
		check("test_readout_packets word count", frames, valid_n);
	endtask

	initial begin
		void'($urandom(32'heb2e));
		sysclk = 1'b0;
		reset = 1'b1;
		data_a = 1'b0;
		button = 1'b0;
		cmp_bias = '0;
		isel_bias = '0;
		sb_bias = '0;
		db_bias = '0;
		cycle_count = 0;
		test_reset_idle();
		test_dreset_pulse();
		test_bias_load();
		test_button();
		test_readout_packets();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

/* list.f */
hw/alpha_pkg.sv
hw/board_pkg.sv
hw/button_debounce.sv
hw/startup_sequencer.sv
hw/bias_shifter.sv
hw/alpha_readout.sv
hw/alpha_test_top.sv
bench/tb_alpha_test.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps \
	--top-module tb_alpha_test \
	-f list.f \
	-o sim_alpha_test

./obj_dir/sim_alpha_test
